//--- hw/booth_pkg.sv
//************************************************
// Shared types for the Booth sequential multiplier:
// controller state encoding and controller/datapath structs.
//************************************************

`default_nettype none

package booth_pkg;

  //************************************************
  // controller state
  //************************************************

  // idle waits for operands, run performs the Booth steps,
  // done holds the product until the sink takes it.
  typedef enum logic [1:0] {
    idle = 2'b00,
    run  = 2'b01,
    done = 2'b10
  } booth_state_e;

  //************************************************
  // controller to datapath
  //************************************************

  // one-hot style strobes, sampled by the datapath on the rising edge.
  typedef struct packed {
    logic load;        // capture operands and clear the running state.
    logic step;        // perform one recode, add and shift step.
    logic add_sel;     // step uses the multiplicand, otherwise shift only.
    logic sub;         // subtract the multiplicand instead of adding it.
    logic product_en;  // load the product register.
  } booth_ctrl_t;

  //************************************************
  // datapath to controller
  //************************************************

  // q0 and q_1 together form the Booth recoding pair.
  typedef struct packed {
    logic q0;          // current multiplier lsb.
    logic q_1;         // bit shifted out by the previous step.
    logic count_done;  // all steps have been taken.
  } booth_status_t;

endpackage : booth_pkg

`default_nettype wire

//--- hw/booth_controller.sv
//************************************************
// Control FSM of the Booth multiplier: operand handshake,
// step sequencing with recoding, product capture and output handshake.
//************************************************

`default_nettype none

module booth_controller (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     src_valid,
  input  logic                     dest_ready,
  input  booth_pkg::booth_status_t status,
  output logic                     src_ready,
  output logic                     dest_valid,
  output booth_pkg::booth_ctrl_t   ctrl
);

  import booth_pkg::*;

  booth_state_e state;
  booth_state_e state_next;

  //************************************************
  // state register
  //************************************************

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  //************************************************
  // next state and output decode
  //************************************************

  always_comb begin
    // defaults keep every output defined in every state.
    state_next = state;
    src_ready  = 1'b0;
    dest_valid = 1'b0;
    ctrl       = '0;

    case (state)
      idle: begin
        src_ready = 1'b1;
        // the datapath picks up the operands on the accepting edge.
        ctrl.load = src_valid;
        if (src_valid) begin
          state_next = run;
        end
      end

      run: begin
        if (status.count_done) begin
          // last cycle in run is a capture cycle, no step is taken.
          ctrl.product_en = 1'b1;
          state_next      = done;
        end else begin
          ctrl.step = 1'b1;
          // Booth radix-2 recoding of the current pair.
          case ({status.q0, status.q_1})
            2'b10: begin
              ctrl.add_sel = 1'b1;
              ctrl.sub     = 1'b1;
            end
            2'b01: begin
              ctrl.add_sel = 1'b1;
              ctrl.sub     = 1'b0;
            end
            default: begin
              // 00 and 11 are a pure shift.
              ctrl.add_sel = 1'b0;
              ctrl.sub     = 1'b0;
            end
          endcase
        end
      end

      done: begin
        // the product is held until the sink takes it.
        dest_valid = 1'b1;
        if (dest_ready) begin
          state_next = idle;
        end
      end

      default: begin
        state_next = idle;
      end
    endcase
  end

endmodule : booth_controller

`default_nettype wire

//--- hw/booth_datapath.sv
//************************************************
// Booth datapath: operand registers, accumulator add/subtract,
// arithmetic right shift, step counter and product register.
//************************************************

`default_nettype none

module booth_datapath #(
  parameter int WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic signed [WIDTH-1:0]       a_in,
  input  logic signed [WIDTH-1:0]       b_in,
  input  booth_pkg::booth_ctrl_t        ctrl,
  output booth_pkg::booth_status_t      status,
  output logic signed [2*WIDTH-1:0]     product
);

  import booth_pkg::*;

  localparam int CNT_W = $clog2(WIDTH + 1);

  typedef logic signed [WIDTH-1:0]   operand_t;
  typedef logic signed [WIDTH:0]     acc_t;
  typedef logic        [CNT_W-1:0]   count_t;
  typedef logic signed [2*WIDTH-1:0] product_t;

  localparam count_t STEPS = count_t'(WIDTH);

  operand_t multiplicand;
  operand_t q_reg;
  acc_t     acc;
  logic     q_hist;
  count_t   count;

  acc_t     m_ext;
  acc_t     acc_sum;
  acc_t     acc_shift;
  operand_t q_shift;

  //************************************************
  // add/subtract and shift
  //************************************************

  // the accumulator carries one guard bit, so the multiplicand is
  // sign extended before the add. this keeps the most negative
  // operand from overflowing.
  assign m_ext = {multiplicand[WIDTH-1], multiplicand};

  always_comb begin
    if (!ctrl.add_sel) begin
      acc_sum = acc;
    end else if (ctrl.sub) begin
      acc_sum = acc - m_ext;
    end else begin
      acc_sum = acc + m_ext;
    end
  end

  // {acc, q} shifts right by one as a single signed value.
  assign acc_shift = {acc_sum[WIDTH], acc_sum[WIDTH:1]};
  assign q_shift   = {acc_sum[0], q_reg[WIDTH-1:1]};

  //************************************************
  // operand and accumulator registers
  //************************************************

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      multiplicand <= a_in;
      q_reg        <= b_in;
      acc          <= '0;
      q_hist       <= 1'b0;
    end else if (ctrl.step) begin
      acc    <= acc_shift;
      q_reg  <= q_shift;
      // the bit leaving the multiplier becomes the history bit.
      q_hist <= q_reg[0];
    end
  end

  //************************************************
  // step counter and product register
  //************************************************

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      count   <= '0;
      product <= '0;
    end else begin
      if (ctrl.load) begin
        count <= '0;
      end else if (ctrl.step) begin
        count <= count + count_t'(1);
      end
      if (ctrl.product_en) begin
        product <= product_t'({acc[WIDTH-1:0], q_reg});
      end
    end
  end

  // status back to the controller.
  assign status.q0         = q_reg[0];
  assign status.q_1        = q_hist;
  assign status.count_done = (count == STEPS);

endmodule : booth_datapath

`default_nettype wire

//--- hw/booth_multiplier.sv
//************************************************
// Top level of the signed Booth multiplier with
// valid/ready stream ports on input and output.
//************************************************

`default_nettype none

module booth_multiplier #(
  parameter int WIDTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic signed [WIDTH-1:0]   a_in,
  input  logic signed [WIDTH-1:0]   b_in,
  input  logic                      src_valid,
  output logic                      src_ready,
  output logic signed [2*WIDTH-1:0] product,
  output logic                      dest_valid,
  input  logic                      dest_ready
);

  import booth_pkg::*;

  booth_ctrl_t   ctrl;
  booth_status_t status;

  // the FSM owns both handshakes.
  booth_controller booth_controller_i (
    .clk        (clk),
    .rst        (rst),
    .src_valid  (src_valid),
    .dest_ready (dest_ready),
    .status     (status),
    .src_ready  (src_ready),
    .dest_valid (dest_valid),
    .ctrl       (ctrl)
  );

  booth_datapath #(
    .WIDTH (WIDTH)
  ) booth_datapath_i (
    .clk     (clk),
    .rst     (rst),
    .a_in    (a_in),
    .b_in    (b_in),
    .ctrl    (ctrl),
    .status  (status),
    .product (product)
  );

endmodule : booth_multiplier

`default_nettype wire

//--- testbench/booth_multiplier_chk.sv
//************************************************
// Bound checker for the Booth multiplier: handshake,
// latency, back-pressure and reset assertions.
//************************************************

`default_nettype none

module booth_multiplier_chk #(
  parameter int WIDTH = 8
) (
  input logic               clk,
  input logic               rst,
  input logic               src_valid,
  input logic               src_ready,
  input logic               dest_valid,
  input logic               dest_ready,
  input logic [2*WIDTH-1:0] product
);

  timeunit 1ns;
  timeprecision 1ps;

  // WIDTH step cycles plus the product capture cycle.
  localparam int LATENCY = WIDTH + 1;

  // read by the testbench top to end the run early.
  int error_count = 0;

  latency_a: assert property (@(posedge clk) disable iff (!rst)
    (src_valid && src_ready) |=> !dest_valid [*LATENCY] ##1 dest_valid)
  else begin
    $error("dest_valid did not rise %0d edges after the accepting edge", LATENCY);
    error_count++;
  end

  // a stalled result must not move or disappear.
  hold_a: assert property (@(posedge clk) disable iff (!rst)
    (dest_valid && !dest_ready) |=> (dest_valid && $stable(product)))
  else begin
    $error("result changed or was dropped under back-pressure");
    error_count++;
  end

  exclusive_a: assert property (@(posedge clk) disable iff (!rst)
    !(src_ready && dest_valid))
  else begin
    $error("src_ready and dest_valid were high together");
    error_count++;
  end

  // the input side reopens only once the pending result was taken.
  reopen_a: assert property (@(posedge clk) disable iff (!rst)
    $rose(src_ready) |-> $past(dest_valid && dest_ready))
  else begin
    $error("src_ready rose without an output transfer");
    error_count++;
  end

  reset_a: assert property (@(posedge clk)
    (!rst || $rose(rst)) |-> (!dest_valid && src_ready))
  else begin
    $error("handshake outputs wrong during or right after reset");
    error_count++;
  end

endmodule : booth_multiplier_chk

bind booth_multiplier booth_multiplier_chk #(.WIDTH(WIDTH)) booth_multiplier_chk_i (.*);

`default_nettype wire

//--- testbench/booth_multiplier_tb.sv
//************************************************
// Testbench for the Booth multiplier: clock, reset,
// LFSR stimulus, expected product queue and product check.
//************************************************

`default_nettype none

module booth_multiplier_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH   = 8;
  localparam int TIMEOUT = 2000;
  localparam int RANDOM_PAIRS = 200;

  typedef logic signed [WIDTH-1:0]   operand_t;
  typedef logic signed [2*WIDTH-1:0] product_t;

  // one accepted operand pair and the product it must produce.
  typedef struct packed {
    operand_t a;
    operand_t b;
    product_t expected;
  } pending_t;

  localparam operand_t MOST_NEG = operand_t'(1) <<< (WIDTH - 1);
  localparam operand_t MOST_POS = ~MOST_NEG;

  logic     clk;
  logic     rst;
  operand_t a_in;
  operand_t b_in;
  logic     src_valid;
  logic     src_ready;
  product_t product;
  logic     dest_valid;
  logic     dest_ready;

  pending_t    pending_q[$];
  pending_t    head;
  logic [31:0] lfsr_state;

  booth_multiplier #(
    .WIDTH (WIDTH)
  ) booth_multiplier_i (
    .clk        (clk),
    .rst        (rst),
    .a_in       (a_in),
    .b_in       (b_in),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .product    (product),
    .dest_valid (dest_valid),
    .dest_ready (dest_ready)
  );

  //************************************************
  // helpers
  //************************************************

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[30:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // full signed product, sign extended before multiplying.
  function automatic product_t expected_product(input operand_t a, input operand_t b);
    product_t wide_a;
    product_t wide_b;
    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // called one ns after an edge, returns one ns after the accepting edge.
  task automatic send_pair(input operand_t a, input operand_t b);
    logic [31:0] gap;
    int          cycles;
    logic        accepted;
    take_bits(2, gap);
    for (int i = 0; i < gap; i++) begin
      @(posedge clk);
      #1;
    end
    a_in      = a;
    b_in      = b;
    src_valid = 1'b1;
    accepted  = 1'b0;
    cycles    = 0;
    while (!accepted) begin
      @(posedge clk);
      if (src_ready) begin
        accepted = 1'b1;
      end else begin
        cycles++;
        if (cycles >= TIMEOUT) begin
          report_failure("timeout: the DUT never accepted an operand pair");
        end
      end
    end
    #1;
    src_valid = 1'b0;
  endtask

  //************************************************
  // clock, sink and monitors
  //************************************************

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random back-pressure, drawn at the falling edge.
  initial begin : sink
    logic [31:0] r;
    dest_ready = 1'b0;
    forever begin
      @(negedge clk);
      r = '0;
      if (rst) begin
        take_bits(1, r);
      end
      @(posedge clk);
      #1;
      dest_ready = r[0];
    end
  end

  always @(posedge clk) begin
    if (rst && src_valid && src_ready) begin
      pending_q.push_back({a_in, b_in, expected_product(a_in, b_in)});
    end
  end

  always @(posedge clk) begin
    if (rst && dest_valid && dest_ready) begin
      if (pending_q.size() == 0) begin
        report_failure("output transfer with no operand pair outstanding");
      end else begin
        head = pending_q.pop_front();
        product_a: assert (product == head.expected)
        else begin
          $display("mismatch at %0t: a=%0d b=%0d expected %0d got %0d", $time,
                   $signed(head.a), $signed(head.b), $signed(head.expected), product);
          report_failure("product check failed");
        end
      end
    end
  end

  always @(posedge clk) begin
    if (booth_multiplier_i.booth_multiplier_chk_i.error_count != 0) begin
      report_failure("a handshake assertion in the checker failed");
    end
  end

  //************************************************
  // main sequence
  //************************************************

  initial begin : main
    logic [31:0] ra;
    logic [31:0] rb;
    int          cycles;
    lfsr_state = 32'd89408;
    rst        = 1'b1;
    a_in       = '0;
    b_in       = '0;
    src_valid  = 1'b0;
    // a clean falling edge on rst starts the asynchronous reset.
    #1;
    rst = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;

    send_pair(operand_t'(0), operand_t'(37));
    send_pair(operand_t'(1), operand_t'(-73));
    send_pair(operand_t'(-1), operand_t'(-1));
    send_pair(operand_t'(-1), MOST_POS);
    send_pair(MOST_NEG, MOST_NEG);
    send_pair(MOST_NEG, MOST_POS);
    send_pair(MOST_POS, MOST_NEG);
    for (int n = 0; n < RANDOM_PAIRS; n++) begin
      take_bits(WIDTH, ra);
      take_bits(WIDTH, rb);
      send_pair(operand_t'(ra[WIDTH-1:0]), operand_t'(rb[WIDTH-1:0]));
    end

    cycles = 0;
    while (pending_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT) begin
        report_failure("timeout: results still outstanding at the end of the test");
      end
    end
    repeat (4) @(posedge clk);

    if (booth_multiplier_i.booth_multiplier_chk_i.error_count != 0) begin
      report_failure("the checker reported assertion failures");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule : booth_multiplier_tb

`default_nettype wire

//--- files.f
hw/booth_pkg.sv
hw/booth_controller.sv
hw/booth_datapath.sv
hw/booth_multiplier.sv
testbench/booth_multiplier_chk.sv
testbench/booth_multiplier_tb.sv

//--- Bender.yml
package:
  name: booth_multiplier

sources:
  # synthesizable RTL, package first
  - files:
      - hw/booth_pkg.sv
      - hw/booth_controller.sv
      - hw/booth_datapath.sv
      - hw/booth_multiplier.sv
  # simulation only
  - target: simulation
    files:
      - testbench/booth_multiplier_chk.sv
      - testbench/booth_multiplier_tb.sv
